// File: hw/dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int num_ways       = 2;
    localparam int num_sets       = 16;
    localparam int words_per_line = 4;
    localparam int index_bits     = 4;
    localparam int offset_bits    = 4;
    localparam int tag_bits       = 24;

    // beats per burst minus one
    localparam logic [7:0] burst_length = 8'd3;

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss,
        replace,
        refill,
        wait_write,
        extra_ready
    } fsm_state_e;

    typedef enum logic {
        op_read,
        op_write
    } mem_op_e;

    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        uncache;
    } cpu_req_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  length;
        logic [2:0]  size;
    } mem_rd_req_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [2:0]  size;
    } mem_wr_req_t;

endpackage

// File: hw/dcache_main_fsm.sv
`timescale 1ns/1ps

module dcache_main_fsm (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    req_valid,
    input  dcache_pkg::cpu_req_t    rbuf,
    input  logic [1:0]              hit,
    input  logic [1:0]              lru_way,
    input  logic                    r_rdy,
    input  logic                    w_rdy,
    input  logic                    fill_finish,
    input  logic                    w_finish,
    output logic                    rbuf_we,
    output logic [1:0]              way_we,
    output logic [1:0]              fill_we,
    output logic                    lru_update,
    output logic                    r_data_ready,
    output logic                    r_req,
    output logic                    w_req,
    output dcache_pkg::mem_rd_req_t rd_req,
    output dcache_pkg::mem_wr_req_t wr_req,
    output logic                    cache_ready,
    output logic                    data_valid,
    output logic                    rdata_sel
);
    import dcache_pkg::*;

    fsm_state_e state_q;
    fsm_state_e state_d;
    logic       cache_hit;
    logic       is_store;
    logic [2:0] strb_size;

    assign cache_hit = (|hit) && !rbuf.uncache;
    assign is_store  = (rbuf.op == op_write);

    // access size from the byte strobe
    always_comb begin
        case (rbuf.wstrb)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: strb_size = 3'd0;
            4'b0011, 4'b1100: strb_size = 3'd1;
            default: strb_size = 3'd2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle: begin
                if (req_valid) state_d = lookup;
            end
            lookup: begin
                if (is_store) begin
                    state_d = miss;
                end else if (cache_hit) begin
                    state_d = req_valid ? lookup : idle;
                end else begin
                    state_d = replace;
                end
            end
            miss: begin
                if (w_rdy) state_d = wait_write;
            end
            replace: begin
                if (r_rdy) state_d = refill;
            end
            refill: begin
                if (fill_finish) state_d = extra_ready;
            end
            wait_write: begin
                if (w_finish) state_d = extra_ready;
            end
            extra_ready: begin
                state_d = req_valid ? lookup : idle;
            end
            default: state_d = idle;
        endcase
    end

    always_comb begin
        rbuf_we      = 1'b0;
        way_we       = 2'b00;
        fill_we      = 2'b00;
        lru_update   = 1'b0;
        r_data_ready = 1'b0;
        r_req        = 1'b0;
        w_req        = 1'b0;
        cache_ready  = 1'b0;
        data_valid   = 1'b0;
        rdata_sel    = 1'b0;
        case (state_q)
            idle: begin
                cache_ready = 1'b1;
                rbuf_we     = req_valid;
            end
            lookup: begin
                rdata_sel = 1'b1;
                if (is_store) begin
                    // write-through, update only on a cached hit
                    way_we     = rbuf.uncache ? 2'b00 : hit;
                    lru_update = cache_hit;
                end else if (cache_hit) begin
                    data_valid  = 1'b1;
                    cache_ready = 1'b1;
                    rbuf_we     = req_valid;
                    lru_update  = 1'b1;
                end
            end
            miss: w_req = 1'b1;
            replace: r_req = 1'b1;
            refill: begin
                r_data_ready = 1'b1;
                if (fill_finish && !rbuf.uncache) begin
                    fill_we    = lru_way;
                    lru_update = 1'b1;
                end
            end
            extra_ready: begin
                data_valid  = 1'b1;
                cache_ready = 1'b1;
                rbuf_we     = req_valid;
            end
            default: ;
        endcase
    end

    always_comb begin
        rd_req.addr   = rbuf.uncache ? rbuf.addr : {rbuf.addr[31:offset_bits], {offset_bits{1'b0}}};
        rd_req.length = rbuf.uncache ? 8'd0 : burst_length;
        rd_req.size   = rbuf.uncache ? strb_size : 3'd2;
        wr_req.addr   = rbuf.addr;
        wr_req.data   = rbuf.wdata;
        wr_req.strb   = rbuf.wstrb;
        wr_req.size   = strb_size;
    end

    a_one_mem_req: assert property (@(posedge clk) disable iff (!rstn)
        !(r_req && w_req));

    a_no_resp_idle: assert property (@(posedge clk) disable iff (!rstn)
        (state_q == idle) |-> !data_valid);

endmodule

// File: hw/dcache_arrays.sv
`timescale 1ns/1ps

module dcache_arrays (
    input  logic         clk,
    input  logic         rstn,
    input  logic [31:0]  addr,
    input  logic [31:0]  wdata,
    input  logic [3:0]   wstrb,
    input  logic [1:0]   way_we,
    input  logic [1:0]   fill_we,
    input  logic [127:0] fill_line,
    input  logic         lru_update,
    output logic [1:0]   hit,
    output logic [1:0]   lru_way,
    output logic [31:0]  hit_word
);
    import dcache_pkg::*;

    logic [tag_bits-1:0]    tag_q   [num_ways][num_sets];
    logic                   valid_q [num_ways][num_sets];
    logic [31:0]            data_q  [num_ways][num_sets][words_per_line];
    logic                   lru_q   [num_sets];
    logic [index_bits-1:0]  index;
    logic [offset_bits-3:0] word_sel;
    logic [tag_bits-1:0]    tag;

    assign index    = addr[offset_bits +: index_bits];
    assign word_sel = addr[offset_bits-1:2];
    assign tag      = addr[31 -: tag_bits];

    always_comb begin
        hit_word = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit[w] = valid_q[w][index] && (tag_q[w][index] == tag);
            if (hit[w]) hit_word = data_q[w][index][word_sel];
        end
        // lru bit holds the victim way
        lru_way = '0;
        lru_way[lru_q[index]] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < num_sets; s++) begin
                lru_q[s] <= 1'b0;
                for (int w = 0; w < num_ways; w++) begin
                    valid_q[w][s] <= 1'b0;
                end
            end
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (fill_we[w]) valid_q[w][index] <= 1'b1;
            end
            if (lru_update) lru_q[index] <= !(hit[1] || fill_we[1]);
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (fill_we[w]) begin
                tag_q[w][index] <= tag;
                for (int k = 0; k < words_per_line; k++) begin
                    data_q[w][index][k] <= fill_line[32*k +: 32];
                end
            end else if (way_we[w]) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) data_q[w][index][word_sel][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    a_hit_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(hit));

endmodule

// File: hw/dcache_refill_buf.sv
`timescale 1ns/1ps

module dcache_refill_buf (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 req_valid,
    input  dcache_pkg::cpu_req_t req,
    input  logic                 rbuf_we,
    input  logic                 r_valid,
    input  logic                 r_data_ready,
    input  logic                 r_last,
    input  logic [31:0]          r_data,
    output dcache_pkg::cpu_req_t rbuf,
    output logic [127:0]         fill_line,
    output logic [31:0]          fill_word,
    output logic                 fill_finish
);
    import dcache_pkg::*;

    logic                   accept;
    logic                   beat;
    logic [offset_bits-3:0] beat_cnt;
    logic [offset_bits-3:0] word_sel;
    logic [31:0]            line_q [words_per_line];

    assign accept      = rbuf_we && req_valid;
    assign beat        = r_valid && r_data_ready;
    assign fill_finish = beat && r_last;

    always_ff @(posedge clk) begin
        if (accept) rbuf <= req;
        if (beat) line_q[beat_cnt] <= r_data;
    end

    // beat position, restarts with every new request
    always_ff @(posedge clk) begin
        if (!rstn || accept) begin
            beat_cnt <= '0;
        end else if (beat) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // line as written into the arrays, including the beat arriving now
    always_comb begin
        for (int k = 0; k < words_per_line; k++) begin
            fill_line[32*k +: 32] = (beat && beat_cnt == (offset_bits-2)'(k)) ? r_data : line_q[k];
        end
    end

    // uncached reads return a single beat in word 0
    assign word_sel  = rbuf.uncache ? '0 : rbuf.addr[offset_bits-1:2];
    assign fill_word = line_q[word_sel];

endmodule

// File: hw/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    req_valid,
    input  dcache_pkg::cpu_req_t    req,
    output logic                    cache_ready,
    output logic                    data_valid,
    output logic [31:0]             rdata,
    output logic                    r_req,
    output dcache_pkg::mem_rd_req_t rd_req,
    input  logic                    r_rdy,
    input  logic                    r_valid,
    input  logic                    r_last,
    input  logic [31:0]             r_data,
    output logic                    r_data_ready,
    output logic                    w_req,
    output dcache_pkg::mem_wr_req_t wr_req,
    input  logic                    w_rdy,
    input  logic                    w_finish
);
    import dcache_pkg::*;

    cpu_req_t     rbuf;
    logic         rbuf_we;
    logic [1:0]   hit;
    logic [1:0]   lru_way;
    logic [1:0]   way_we;
    logic [1:0]   fill_we;
    logic         lru_update;
    logic         fill_finish;
    logic         rdata_sel;
    logic [127:0] fill_line;
    logic [31:0]  fill_word;
    logic [31:0]  hit_word;

    // hit data in lookup, refill data otherwise
    assign rdata = rdata_sel ? hit_word : fill_word;

    dcache_main_fsm u_main_fsm (
        .clk          (clk),
        .rstn         (rstn),
        .req_valid    (req_valid),
        .rbuf         (rbuf),
        .hit          (hit),
        .lru_way      (lru_way),
        .r_rdy        (r_rdy),
        .w_rdy        (w_rdy),
        .fill_finish  (fill_finish),
        .w_finish     (w_finish),
        .rbuf_we      (rbuf_we),
        .way_we       (way_we),
        .fill_we      (fill_we),
        .lru_update   (lru_update),
        .r_data_ready (r_data_ready),
        .r_req        (r_req),
        .w_req        (w_req),
        .rd_req       (rd_req),
        .wr_req       (wr_req),
        .cache_ready  (cache_ready),
        .data_valid   (data_valid),
        .rdata_sel    (rdata_sel)
    );

    dcache_arrays u_arrays (
        .clk        (clk),
        .rstn       (rstn),
        .addr       (rbuf.addr),
        .wdata      (rbuf.wdata),
        .wstrb      (rbuf.wstrb),
        .way_we     (way_we),
        .fill_we    (fill_we),
        .fill_line  (fill_line),
        .lru_update (lru_update),
        .hit        (hit),
        .lru_way    (lru_way),
        .hit_word   (hit_word)
    );

    dcache_refill_buf u_refill_buf (
        .clk          (clk),
        .rstn         (rstn),
        .req_valid    (req_valid),
        .req          (req),
        .rbuf_we      (rbuf_we),
        .r_valid      (r_valid),
        .r_data_ready (r_data_ready),
        .r_last       (r_last),
        .r_data       (r_data),
        .rbuf         (rbuf),
        .fill_line    (fill_line),
        .fill_word    (fill_word),
        .fill_finish  (fill_finish)
    );

endmodule

// File: tests/mem_model.sv
`timescale 1ns/1ps

module mem_model (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    r_req,
    input  dcache_pkg::mem_rd_req_t rd_req,
    output logic                    r_rdy,
    output logic                    r_valid,
    output logic                    r_last,
    output logic [31:0]             r_data,
    input  logic                    r_data_ready,
    input  logic                    w_req,
    input  dcache_pkg::mem_wr_req_t wr_req,
    output logic                    w_rdy,
    output logic                    w_finish,
    input  logic [31:0]             peek_addr,
    output logic [31:0]             peek_data
);
    // words written so far, all others still hold the fill pattern
    logic [31:0] written [logic [31:0]];
    logic [31:0] rd_addr;
    logic [7:0]  beats_left;
    logic        rd_busy;
    logic        wr_busy;
    logic [1:0]  wr_delay;
    logic [31:0] rnd;
    integer      seed;

    function automatic logic [31:0] word_at(input logic [31:0] a);
        logic [31:0] wa;
        wa = {a[31:2], 2'b00};
        if (written.exists(wa)) return written[wa];
        return wa ^ 32'h5a5a0000;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] data,
                                                input logic [3:0]  strb);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) merged[8*b +: 8] = data[8*b +: 8];
        end
        return merged;
    endfunction

    initial begin
        seed       = 32'h706719a1;
        r_rdy      = 1'b0;
        r_valid    = 1'b0;
        r_last     = 1'b0;
        r_data     = '0;
        w_rdy      = 1'b0;
        w_finish   = 1'b0;
        peek_data  = '0;
        rd_addr    = '0;
        beats_left = '0;
        rd_busy    = 1'b0;
        wr_busy    = 1'b0;
        wr_delay   = '0;
    end

    always @(posedge clk) begin
        rnd = $random(seed);
        w_finish  <= 1'b0;
        peek_data <= word_at(peek_addr);
        if (!rstn) begin
            r_rdy    <= 1'b0;
            r_valid  <= 1'b0;
            r_last   <= 1'b0;
            w_rdy    <= 1'b0;
            rd_busy  <= 1'b0;
            wr_busy  <= 1'b0;
            wr_delay <= 2'd0;
        end else begin
            // one beat at a time, random gaps between beats
            if (r_req && r_rdy) begin
                r_rdy      <= 1'b0;
                rd_busy    <= 1'b1;
                rd_addr    <= rd_req.addr;
                beats_left <= rd_req.length;
            end else if (rd_busy) begin
                if (r_valid && r_data_ready) begin
                    r_valid <= 1'b0;
                    r_last  <= 1'b0;
                    rd_addr <= rd_addr + 32'd4;
                    if (r_last) rd_busy <= 1'b0;
                end else if (!r_valid && rnd[0]) begin
                    r_valid    <= 1'b1;
                    r_last     <= (beats_left == 8'd0);
                    r_data     <= word_at(rd_addr);
                    beats_left <= beats_left - 8'd1;
                end
            end else begin
                r_rdy <= r_req && rnd[1];
            end

            if (w_req && w_rdy) begin
                w_rdy    <= 1'b0;
                wr_busy  <= 1'b1;
                wr_delay <= rnd[3:2];
                written[{wr_req.addr[31:2], 2'b00}] =
                    merge_bytes(word_at(wr_req.addr), wr_req.data, wr_req.strb);
            end else if (wr_busy) begin
                if (wr_delay == 2'd0) begin
                    w_finish <= 1'b1;
                    wr_busy  <= 1'b0;
                end else begin
                    wr_delay <= wr_delay - 2'd1;
                end
            end else begin
                w_rdy <= w_req && rnd[4];
            end
        end
    end

endmodule

// File: tests/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int num_patterns = 18;
    localparam int num_fields   = 7;
    localparam int max_cycles   = num_patterns * 40;

    logic        clk;
    logic        rstn;
    logic        req_valid;
    cpu_req_t    req;
    logic        cache_ready;
    logic        data_valid;
    logic [31:0] rdata;
    logic        r_req;
    mem_rd_req_t rd_req;
    logic        r_rdy;
    logic        r_valid;
    logic        r_last;
    logic [31:0] r_data;
    logic        r_data_ready;
    logic        w_req;
    mem_wr_req_t wr_req;
    logic        w_rdy;
    logic        w_finish;
    logic [31:0] peek_addr;
    logic [31:0] peek_data;

    logic [31:0] pattern_mem [num_patterns*num_fields];
    int          cycle    = 0;
    int          rd_count = 0;
    int          wr_count = 0;
    int          dv_count = 0;
    int          accesses = 0;
    mem_rd_req_t last_rd;
    mem_wr_req_t last_wr;

    dcache_top u_dcache_top (.*);

    mem_model u_mem_model (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (r_req && r_rdy) begin
            rd_count <= rd_count + 1;
            last_rd  <= rd_req;
        end
        if (w_req && w_rdy) begin
            wr_count <= wr_count + 1;
            last_wr  <= wr_req;
        end
        if (data_valid) dv_count <= dv_count + 1;
        if (cycle >= max_cycles) begin
            $display("timeout: the DUT did not finish within %0d cycles", max_cycles);
            $display("TESTS FAILED");
            $fatal(1, "simulation timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // transfer size is log2 of the number of enabled bytes
    function automatic logic [31:0] size_from_strobe(input logic [3:0] strb);
        case ($countones(strb))
            1: return 32'd0;
            2: return 32'd1;
            default: return 32'd2;
        endcase
    endfunction

    // one CPU access, waits for its single response
    task automatic run_access(input int idx);
        logic [31:0] op;
        logic [31:0] unc;
        logic [31:0] addr;
        logic [31:0] exp_rd;
        logic [3:0]  strb;
        int          rd_before;
        int          wr_before;
        int          accept_cycle;
        op        = pattern_mem[idx*num_fields];
        unc       = pattern_mem[idx*num_fields+1];
        addr      = pattern_mem[idx*num_fields+2];
        strb      = pattern_mem[idx*num_fields+4][3:0];
        exp_rd    = pattern_mem[idx*num_fields+6];
        rd_before = rd_count;
        wr_before = wr_count;
        @(posedge clk);
        req_valid <= 1'b1;
        req <= '{op: mem_op_e'(op[0]), addr: addr, wdata: pattern_mem[idx*num_fields+3],
                 wstrb: strb, uncache: unc[0]};
        @(negedge clk);
        while (!cache_ready) @(negedge clk);
        accept_cycle = cycle;
        @(posedge clk);
        req_valid <= 1'b0;
        @(negedge clk);
        while (!data_valid) @(negedge clk);
        accesses++;
        if (op[0] == 1'b0) begin
            check_value("rdata", rdata, pattern_mem[idx*num_fields+5]);
            // cached hits answer in the cycle after acceptance
            if (!unc[0] && exp_rd == 0) check_value("hit latency", cycle - accept_cycle, 1);
        end
        check_value("read requests", rd_count - rd_before, exp_rd);
        if (exp_rd != 0) begin
            check_value("rd_req.length", 32'(last_rd.length), unc[0] ? 32'd0 : 32'd3);
            check_value("rd_req.addr", last_rd.addr, unc[0] ? addr : {addr[31:4], 4'h0});
            check_value("rd_req.size", 32'(last_rd.size),
                        unc[0] ? size_from_strobe(strb) : 32'd2);
        end
        // every store is one single-beat write, loads write nothing
        check_value("write requests", wr_count - wr_before, 32'(op[0]));
        if (op[0] == 1'b1) begin
            check_value("wr_req.addr", last_wr.addr, addr);
            check_value("wr_req.size", 32'(last_wr.size), size_from_strobe(strb));
        end
    endtask

    task automatic check_memory(input int idx);
        @(posedge clk);
        peek_addr <= pattern_mem[idx*num_fields+2];
        @(posedge clk);
        @(negedge clk);
        check_value("memory word", peek_data, pattern_mem[idx*num_fields+5]);
    endtask

    initial begin
        rstn      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        peek_addr = '0;
        $readmemh("tests/dcache_patterns.txt", pattern_mem);
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        for (int i = 0; i < num_patterns; i++) begin
            if (pattern_mem[i*num_fields] == 32'd2) begin
                check_memory(i);
            end else begin
                run_access(i);
            end
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("data_valid count", dv_count, accesses);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: tests/dcache_patterns.txt
// op uncache addr wdata wstrb exp_rdata exp_read_req
// op: 0 load, 1 store, 2 compare memory word at addr with exp_rdata
0 0 00001000 00000000 f 5a5a1000 1
0 0 00001008 00000000 f 5a5a1008 0
1 0 00001004 aabbccdd 3 00000000 0
0 0 00001004 00000000 f 5a5accdd 0
2 0 00001004 00000000 0 5a5accdd 0
1 0 00002010 12345678 f 00000000 0
2 0 00002010 00000000 0 12345678 0
0 0 00002010 00000000 f 12345678 1
0 0 0000201c 00000000 f 5a5a201c 0
0 1 00001004 00000000 f 5a5accdd 1
0 1 00003024 00000000 f 5a5a3024 1
0 0 00010030 00000000 f 5a5b0030 1
0 0 00020030 00000000 f 5a580030 1
0 0 00030030 00000000 f 5a590030 1
0 0 00020034 00000000 f 5a580034 0
0 0 00010038 00000000 f 5a5b0038 1
0 0 0002003c 00000000 f 5a58003c 0
0 0 00030034 00000000 f 5a590034 1

// File: tb.f
hw/dcache_pkg.sv
hw/dcache_main_fsm.sv
hw/dcache_arrays.sv
hw/dcache_refill_buf.sv
hw/dcache_top.sv
tests/mem_model.sv
tests/tb_dcache.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert -Wno-fatal -f tb.f --top-module tb_dcache -Mdir "$build_dir"
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

"$build_dir/Vtb_dcache" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$log_file"; then
    exit 0
fi
echo "pass message not found in $log_file"
exit 1
